/* Makefile */
TOP := tb_sonata_lite
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/sonata_lite_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module sonata_lite_assertions (
  input wire clk_i,
  input wire arst_n_i,
  input wire req_i,
  input wire ack_i,
  input wire gpio_req_i,
  input wire timer_req_i,
  input wire irq_i
);

  // Number of failed assertions.
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////
  // Host handshake.
  //////////////////////////////////////////////////

  ack_rise_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_i) |-> req_i)
    else begin
      fail_count = fail_count + 1;
      $error("ack rose while req was low");
    end

  // Ack is held until the host drops req.
  ack_held_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_i && req_i) |=> ack_i)
    else begin
      fail_count = fail_count + 1;
      $error("ack fell while req was still high");
    end

  one_device_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(gpio_req_i && timer_req_i))
    else begin
      fail_count = fail_count + 1;
      $error("both device strobes active in one cycle");
    end

  //////////////////////////////////////////////////
  // Timer interrupt.
  //////////////////////////////////////////////////

  irq_low_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !irq_i)
    else begin
      fail_count = fail_count + 1;
      $error("timer interrupt high right after reset");
    end

endmodule

bind bus_fabric sonata_lite_assertions u_fabric_checks (
  .clk_i      (clk_sys_i),
  .arst_n_i   (arst_n_i),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .gpio_req_i (gpio_req_o),
  .timer_req_i(timer_req_o),
  .irq_i      (1'b0)
);

// The timer has no host handshake, only its strobe and interrupt.
bind timer_regs sonata_lite_assertions u_timer_checks (
  .clk_i      (clk_sys_i),
  .arst_n_i   (arst_n_i),
  .req_i      (1'b0),
  .ack_i      (1'b0),
  .gpio_req_i (1'b0),
  .timer_req_i(req_i),
  .irq_i      (timer_irq_o)
);

`default_nettype wire

/* bench/tb_sonata_lite.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sonata_lite import sonata_lite_pkg::*; ();

  localparam int unsigned NumAccesses     = 16;
  localparam int unsigned CyclesPerAccess = 64;
  localparam int unsigned WatchdogCycles  = NumAccesses * CyclesPerAccess;

  logic      clk_sys_i;
  logic      arst_n_i;
  logic      req_i;
  bus_addr_t addr_i;
  logic      we_i;
  bus_be_t   be_i;
  bus_data_t wdata_i;
  logic      ack_o;
  bus_data_t rdata_o;
  logic      err_o;
  gpi_t      gp_i;
  gpo_t      gp_o;
  logic      timer_irq_o;

  logic [31:0] lfsr_state;
  gpo_t        gp_expect;
  bus_data_t   last_time;

  sonata_lite_top DUT (
    .clk_sys_i  (clk_sys_i),
    .arst_n_i   (arst_n_i),
    .req_i      (req_i),
    .addr_i     (addr_i),
    .we_i       (we_i),
    .be_i       (be_i),
    .wdata_i    (wdata_i),
    .ack_o      (ack_o),
    .rdata_o    (rdata_o),
    .err_o      (err_o),
    .gp_i       (gp_i),
    .gp_o       (gp_o),
    .timer_irq_o(timer_irq_o)
  );

  always #2 clk_sys_i = ~clk_sys_i;

  //////////////////////////////////////////////////
  // Helpers.
  //////////////////////////////////////////////////

  // Taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic bus_data_t take_bits(int unsigned count);
    bus_data_t bits;
    bits = '0;
    for (int unsigned i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[BusDataWidth-2:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_data(bus_data_t got, bus_data_t exp, string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s, got %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_gpo(gpo_t got, gpo_t exp, string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s, got %h, expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_flag(bit got, bit exp, string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s, got %0b, expected %0b",
                                  $time, what, got, exp));
    end
  endtask

  // Four-phase access; sampled values are the ones before each edge.
  task automatic bus_access(input bus_addr_t addr, input logic we, input bus_be_t be,
                            input bus_data_t wdata, output bus_data_t rdata,
                            output logic err);
    @(posedge clk_sys_i);
    req_i   <= 1'b1;
    addr_i  <= addr;
    we_i    <= we;
    be_i    <= be;
    wdata_i <= wdata;
    do begin
      @(posedge clk_sys_i);
    end while (ack_o !== 1'b1);
    rdata = rdata_o;
    err   = err_o;
    req_i <= 1'b0;
    do begin
      @(posedge clk_sys_i);
    end while (ack_o !== 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Directed tests.
  //////////////////////////////////////////////////

  task automatic gpio_write_readback();
    bus_data_t wdata;
    bus_data_t rdata;
    logic      err;
    wdata = take_bits(BusDataWidth);
    bus_access(GpioBase | bus_addr_t'(GpioOutOffset), 1'b1, 4'hf, wdata, rdata, err);
    check_flag(err, 1'b0, "GPIO output write err");
    check_data(rdata, '0, "GPIO output write rdata");
    gp_expect = wdata[GpoWidth-1:0];
    check_gpo(gp_o, gp_expect, "gp_o after full write");
    bus_access(GpioBase | bus_addr_t'(GpioOutOffset), 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "GPIO output read err");
    check_data(rdata, {{(BusDataWidth-GpoWidth){1'b0}}, gp_expect}, "GPIO output readback");
  endtask

  task automatic gpio_byte_enables();
    bus_data_t wdata;
    bus_data_t rdata;
    logic      err;
    wdata = take_bits(BusDataWidth);
    bus_access(GpioBase | bus_addr_t'(GpioOutOffset), 1'b1, 4'b0010, wdata, rdata, err);
    check_flag(err, 1'b0, "GPIO lane 1 write err");
    // Lane 1 is bits 15:8.
    gp_expect[15:8] = wdata[15:8];
    check_gpo(gp_o, gp_expect, "gp_o after lane 1 write");
  endtask

  task automatic gpio_input();
    gpi_t      gpi_val;
    bus_data_t rdata;
    logic      err;
    gpi_val = gpi_t'(take_bits(GpiWidth));
    @(posedge clk_sys_i);
    gp_i <= gpi_val;
    repeat (4) @(posedge clk_sys_i);
    bus_access(GpioBase | bus_addr_t'(GpioInOffset), 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "GPIO input read err");
    check_data(rdata, {{(BusDataWidth-GpiWidth){1'b0}}, gpi_val}, "GPIO input read");
  endtask

  task automatic timer_interrupt();
    bus_addr_t time_addr;
    bus_addr_t cmp_addr;
    bus_data_t first_time;
    bus_data_t rdata;
    logic      err;
    time_addr = TimerBase | bus_addr_t'(TimerTimeOffset);
    cmp_addr  = TimerBase | bus_addr_t'(TimerCmpOffset);
    bus_access(time_addr, 1'b1, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "time write err");
    bus_access(cmp_addr, 1'b1, 4'hf, '1, rdata, err);
    check_flag(err, 1'b0, "compare write err");
    bus_access(time_addr, 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "first time read err");
    first_time = rdata;
    bus_access(time_addr, 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "second time read err");
    check_flag(rdata > first_time, 1'b1, "time counter increases between reads");
    last_time = rdata;
    check_flag(timer_irq_o, 1'b0, "irq with compare all ones");
    bus_access(cmp_addr, 1'b1, 4'hf, '0, rdata, err);
    check_flag(timer_irq_o, 1'b1, "irq with compare zero");
    bus_access(cmp_addr, 1'b1, 4'hf, '1, rdata, err);
    check_flag(timer_irq_o, 1'b0, "irq after compare set back to all ones");
  endtask

  task automatic error_replies();
    bus_data_t wdata;
    bus_data_t rdata;
    logic      err;
    wdata = take_bits(BusDataWidth);
    bus_access(32'h1000_0000, 1'b1, 4'hf, wdata, rdata, err);
    check_flag(err, 1'b1, "unmapped write err");
    check_data(rdata, '0, "unmapped write rdata");
    bus_access(32'h1000_0000, 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b1, "unmapped read err");
    check_data(rdata, '0, "unmapped read rdata");
    bus_access(GpioBase | bus_addr_t'(GpioInOffset), 1'b1, 4'hf, wdata, rdata, err);
    check_flag(err, 1'b1, "GPIO input write err");
    check_data(rdata, '0, "GPIO input write rdata");
    check_gpo(gp_o, gp_expect, "gp_o after rejected writes");
    bus_access(TimerBase | 32'h0000_0008, 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b1, "timer offset 8 read err");
    check_data(rdata, '0, "timer offset 8 read rdata");
    bus_access(TimerBase | bus_addr_t'(TimerCmpOffset), 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "compare read err");
    check_data(rdata, '1, "compare after error accesses");
    bus_access(TimerBase | bus_addr_t'(TimerTimeOffset), 1'b0, 4'hf, '0, rdata, err);
    check_flag(err, 1'b0, "time read err");
    check_flag(rdata > last_time, 1'b1, "time still counting after error accesses");
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog.
  //////////////////////////////////////////////////

  initial begin
    int unsigned assert_fails;
    clk_sys_i  = 1'b0;
    arst_n_i   = 1'b0;
    req_i      = 1'b0;
    addr_i     = '0;
    we_i       = 1'b0;
    be_i       = '0;
    wdata_i    = '0;
    gp_i       = '0;
    lfsr_state = 32'h23b0_a84a;
    gp_expect  = '0;
    last_time  = '0;
    repeat (2) @(posedge clk_sys_i);
    arst_n_i <= 1'b1;
    check_flag(ack_o, 1'b0, "ack after reset");
    check_flag(timer_irq_o, 1'b0, "irq after reset");
    check_gpo(gp_o, '0, "gp_o after reset");
    gpio_write_readback();
    gpio_byte_enables();
    gpio_input();
    timer_interrupt();
    error_replies();
    assert_fails = DUT.u_bus_fabric.u_fabric_checks.fail_count
                 + DUT.u_timer.u_timer_checks.fail_count;
    if (assert_fails != 0) begin
      stop_with_failure($sformatf("%0d assertion failures occurred during the run.",
                                  assert_fails));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_sys_i);
    stop_with_failure($sformatf("Timeout: the tests did not finish within %0d clock cycles.",
                                WatchdogCycles));
  end

endmodule

`default_nettype wire

/* source/bus_fabric.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_fabric import sonata_lite_pkg::*; (
  input  wire            clk_sys_i,
  input  wire            arst_n_i,

  // Host port, four-phase req/ack.
  input  wire            req_i,
  input  wire bus_addr_t addr_i,
  input  wire            we_i,
  input  wire bus_be_t   be_i,
  input  wire bus_data_t wdata_i,
  output logic           ack_o,
  output bus_data_t      rdata_o,
  output logic           err_o,

  // Device side.
  output logic           gpio_req_o,
  output logic           timer_req_o,
  output reg_addr_t      reg_addr_o,
  output logic           we_o,
  output bus_be_t        be_o,
  output bus_data_t      wdata_o,
  input  wire            gpio_rvalid_i,
  input  wire bus_data_t gpio_rdata_i,
  input  wire            gpio_err_i,
  input  wire            timer_rvalid_i,
  input  wire bus_data_t timer_rdata_i,
  input  wire            timer_err_i
);

  fabric_state_e state_q;
  fabric_state_e state_d;

  // Request as latched from the host.
  bus_addr_t addr_q;
  logic      we_q;
  bus_be_t   be_q;
  bus_data_t wdata_q;

  logic      decoded_q;
  logic      strobe_q;
  logic      rsp_due_q;
  logic      sel_gpio_q;
  logic      sel_timer_q;
  logic      gpio_hit;
  logic      timer_hit;

  logic      rsp_ready;
  logic      rsp_take;
  bus_data_t rsp_rdata;
  logic      rsp_err;
  bus_data_t rdata_q;
  logic      err_q;

  assign gpio_hit  = (addr_q & ~DeviceMask) == GpioBase;
  assign timer_hit = (addr_q & ~DeviceMask) == TimerBase;

  //////////////////////////////////////////////////
  // Handshake FSM.
  //////////////////////////////////////////////////

  assign rsp_take = (state_q == FabricAccess) && decoded_q && rsp_ready;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FabricIdle: begin
        if (req_i) begin
          state_d = FabricAccess;
        end
      end
      FabricAccess: begin
        if (rsp_take) begin
          state_d = FabricAck;
        end
      end
      FabricAck: begin
        if (!req_i) begin
          state_d = FabricIdle;
        end
      end
      default: state_d = FabricIdle;
    endcase
  end

  // First ACCESS cycle decodes, the strobe goes out the cycle after.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= FabricIdle;
      decoded_q   <= 1'b0;
      strobe_q    <= 1'b0;
      rsp_due_q   <= 1'b0;
      sel_gpio_q  <= 1'b0;
      sel_timer_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      state_q   <= state_d;
      strobe_q  <= 1'b0;
      rsp_due_q <= strobe_q;
      if (state_q == FabricIdle) begin
        decoded_q <= 1'b0;
      end else if (state_q == FabricAccess && !decoded_q) begin
        decoded_q   <= 1'b1;
        strobe_q    <= 1'b1;
        sel_gpio_q  <= gpio_hit;
        sel_timer_q <= timer_hit;
      end
      if (rsp_take) begin
        err_q <= rsp_err;
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (state_q == FabricIdle && req_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
    if (rsp_take) begin
      rdata_q <= rsp_rdata;
    end
  end

  //////////////////////////////////////////////////
  // Response combiner.
  //////////////////////////////////////////////////

  // Unmapped addresses answer one cycle after the would-be strobe.
  always_comb begin
    rsp_ready = 1'b0;
    rsp_rdata = '0;
    rsp_err   = 1'b0;
    if (sel_gpio_q) begin
      rsp_ready = gpio_rvalid_i;
      rsp_rdata = gpio_rdata_i;
      rsp_err   = gpio_err_i;
    end else if (sel_timer_q) begin
      rsp_ready = timer_rvalid_i;
      rsp_rdata = timer_rdata_i;
      rsp_err   = timer_err_i;
    end else begin
      rsp_ready = rsp_due_q;
      rsp_err   = 1'b1;
    end
  end

  assign ack_o       = (state_q == FabricAck);
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign gpio_req_o  = strobe_q & sel_gpio_q;
  assign timer_req_o = strobe_q & sel_timer_q;
  assign reg_addr_o  = addr_q[RegAddrWidth-1:0];
  assign we_o        = we_q;
  assign be_o        = be_q;
  assign wdata_o     = wdata_q;

endmodule

`default_nettype wire

/* source/gpio_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module gpio_regs import sonata_lite_pkg::*; (
  input  wire            clk_sys_i,
  input  wire            arst_n_i,

  input  wire            req_i,
  input  wire reg_addr_t reg_addr_i,
  input  wire            we_i,
  input  wire bus_be_t   be_i,
  input  wire bus_data_t wdata_i,
  output logic           rvalid_o,
  output bus_data_t      rdata_o,
  output logic           err_o,

  input  wire gpi_t      gp_i,
  output gpo_t           gp_o
);

  gpo_t      gp_q;
  gpi_t      gpi_sync1_q;
  gpi_t      gpi_sync2_q;
  logic      rvalid_q;
  logic      err_q;
  bus_data_t rdata_q;
  bus_data_t gpo_merged;
  logic      out_sel;
  logic      in_sel;

  assign out_sel    = (reg_addr_i == GpioOutOffset);
  assign in_sel     = (reg_addr_i == GpioInOffset);
  assign gpo_merged = apply_be(bus_data_t'(gp_q), wdata_i, be_i);

  // Inputs are asynchronous to the system clock.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpi_sync1_q <= '0;
      gpi_sync2_q <= '0;
    end else begin
      gpi_sync1_q <= gp_i;
      gpi_sync2_q <= gpi_sync1_q;
    end
  end

  // Input register is read only.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gp_q     <= '0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & ~(out_sel | (in_sel & ~we_i));
      if (req_i && we_i && out_sel) begin
        gp_q <= gpo_t'(gpo_merged);
      end
    end
  end

  // Writes and errors read back zero.
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_q <= '0;
      if (!we_i && out_sel) begin
        rdata_q <= bus_data_t'(gp_q);
      end else if (!we_i && in_sel) begin
        rdata_q <= bus_data_t'(gpi_sync2_q);
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;
  assign gp_o     = gp_q;

endmodule

`default_nettype wire

/* source/sonata_lite_pkg.sv */
`default_nettype none

package sonata_lite_pkg;

  //////////////////////////////////////////////////
  // Bus and pin widths.
  //////////////////////////////////////////////////

  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;
  localparam int unsigned RegAddrWidth  = 8;
  localparam int unsigned GpiWidth      = 13;
  localparam int unsigned GpoWidth      = 24;

  typedef logic [BusAddrWidth-1:0]  bus_addr_t;
  typedef logic [BusDataWidth-1:0]  bus_data_t;
  typedef logic [BusByteEnable-1:0] bus_be_t;
  typedef logic [RegAddrWidth-1:0]  reg_addr_t;
  typedef logic [GpiWidth-1:0]      gpi_t;
  typedef logic [GpoWidth-1:0]      gpo_t;

  //////////////////////////////////////////////////
  // Address map and register offsets.
  //////////////////////////////////////////////////

  // A region matches on the address bits outside the mask.
  localparam bus_addr_t GpioBase   = 32'h8000_0000;
  localparam bus_addr_t TimerBase  = 32'h8004_0000;
  localparam bus_addr_t DeviceMask = 32'h0000_FFFF;

  localparam reg_addr_t GpioOutOffset   = 8'h00;
  localparam reg_addr_t GpioInOffset    = 8'h04;
  localparam reg_addr_t TimerTimeOffset = 8'h00;
  localparam reg_addr_t TimerCmpOffset  = 8'h04;

  // Host handshake state of the fabric.
  typedef enum logic [1:0] {
    FabricIdle,
    FabricAccess,
    FabricAck
  } fabric_state_e;

  // Merge write data into a register, one byte lane per enable bit.
  function automatic bus_data_t apply_be(bus_data_t old_val, bus_data_t new_val, bus_be_t be);
    bus_data_t result;
    result = old_val;
    for (int i = 0; i < BusByteEnable; i++) begin
      if (be[i]) begin
        result[i*8 +: 8] = new_val[i*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

`default_nettype wire

/* source/sonata_lite_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sonata_lite_top import sonata_lite_pkg::*; (
  input  wire            clk_sys_i,
  input  wire            arst_n_i,

  // Host port.
  input  wire            req_i,
  input  wire bus_addr_t addr_i,
  input  wire            we_i,
  input  wire bus_be_t   be_i,
  input  wire bus_data_t wdata_i,
  output logic           ack_o,
  output bus_data_t      rdata_o,
  output logic           err_o,

  // Pins and interrupt.
  input  wire gpi_t      gp_i,
  output gpo_t           gp_o,
  output logic           timer_irq_o
);

  // Shared register bus.
  reg_addr_t reg_addr;
  logic      reg_we;
  bus_be_t   reg_be;
  bus_data_t reg_wdata;

  // Per device strobes and replies.
  logic      gpio_req;
  logic      gpio_rvalid;
  bus_data_t gpio_rdata;
  logic      gpio_err;
  logic      timer_req;
  logic      timer_rvalid;
  bus_data_t timer_rdata;
  logic      timer_err;

  bus_fabric u_bus_fabric (
    .clk_sys_i     (clk_sys_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .addr_i        (addr_i),
    .we_i          (we_i),
    .be_i          (be_i),
    .wdata_i       (wdata_i),
    .ack_o         (ack_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .gpio_req_o    (gpio_req),
    .timer_req_o   (timer_req),
    .reg_addr_o    (reg_addr),
    .we_o          (reg_we),
    .be_o          (reg_be),
    .wdata_o       (reg_wdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .gpio_err_i    (gpio_err),
    .timer_rvalid_i(timer_rvalid),
    .timer_rdata_i (timer_rdata),
    .timer_err_i   (timer_err)
  );

  gpio_regs u_gpio (
    .clk_sys_i (clk_sys_i),
    .arst_n_i  (arst_n_i),
    .req_i     (gpio_req),
    .reg_addr_i(reg_addr),
    .we_i      (reg_we),
    .be_i      (reg_be),
    .wdata_i   (reg_wdata),
    .rvalid_o  (gpio_rvalid),
    .rdata_o   (gpio_rdata),
    .err_o     (gpio_err),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  timer_regs u_timer (
    .clk_sys_i  (clk_sys_i),
    .arst_n_i   (arst_n_i),
    .req_i      (timer_req),
    .reg_addr_i (reg_addr),
    .we_i       (reg_we),
    .be_i       (reg_be),
    .wdata_i    (reg_wdata),
    .rvalid_o   (timer_rvalid),
    .rdata_o    (timer_rdata),
    .err_o      (timer_err),
    .timer_irq_o(timer_irq_o)
  );

endmodule

`default_nettype wire

/* source/timer_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module timer_regs import sonata_lite_pkg::*; (
  input  wire            clk_sys_i,
  input  wire            arst_n_i,

  input  wire            req_i,
  input  wire reg_addr_t reg_addr_i,
  input  wire            we_i,
  input  wire bus_be_t   be_i,
  input  wire bus_data_t wdata_i,
  output logic           rvalid_o,
  output bus_data_t      rdata_o,
  output logic           err_o,

  output logic           timer_irq_o
);

  bus_data_t time_q;
  bus_data_t cmp_q;
  bus_data_t rdata_q;
  logic      rvalid_q;
  logic      err_q;
  logic      irq_q;

  logic      time_sel;
  logic      cmp_sel;
  logic      time_wr;
  logic      cmp_wr;

  //////////////////////////////////////////////////
  // Register decode.
  //////////////////////////////////////////////////

  assign time_sel = (reg_addr_i == TimerTimeOffset);
  assign cmp_sel  = (reg_addr_i == TimerCmpOffset);
  assign time_wr  = req_i & we_i & time_sel;
  assign cmp_wr   = req_i & we_i & cmp_sel;

  //////////////////////////////////////////////////
  // Counter, compare and interrupt.
  //////////////////////////////////////////////////

  // Compare starts at all ones, so no interrupt out of reset.
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      time_q   <= '0;
      cmp_q    <= '1;
      irq_q    <= 1'b0;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & ~(time_sel | cmp_sel);

      // A write replaces the increment for that cycle.
      if (time_wr) begin
        time_q <= apply_be(time_q, wdata_i, be_i);
      end else begin
        time_q <= time_q + 1'b1;
      end

      if (cmp_wr) begin
        cmp_q <= apply_be(cmp_q, wdata_i, be_i);
      end

      irq_q <= (time_q >= cmp_q);
    end
  end

  // Reads return the value before this cycle's update.
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_q <= '0;
      if (!we_i && time_sel) begin
        rdata_q <= time_q;
      end else if (!we_i && cmp_sel) begin
        rdata_q <= cmp_q;
      end
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* src.f */
source/sonata_lite_pkg.sv
source/bus_fabric.sv
source/gpio_regs.sv
source/timer_regs.sv
source/sonata_lite_top.sv
bench/sonata_lite_assertions.sv
bench/tb_sonata_lite.sv
